/* rtl/mem_pkg.sv */
package mem_pkg;

    //--------------------
    // Sizes
    //--------------------
    localparam int L2_PR_NUM  = 6;
    localparam int L2_ROB_NUM = 5;

    // Entries in the issue queue
    localparam int IQ_DEPTH   = 4;

    //--------------------
    // Types
    //--------------------
    typedef logic [31:0]           xlen_t;
    typedef logic [L2_PR_NUM-1:0]  preg_idx_t;
    typedef logic [L2_ROB_NUM-1:0] rob_idx_t;
    typedef logic [11:0]           imm_t;
    typedef logic [3:0]            strb_t;

    // Bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the size
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010
    } mem_op_t;

endpackage

/* rtl/mem_issue_queue.sv */
`timescale 1ns/1ps

module mem_issue_queue (
    input  logic                clk,
    input  logic                reset,

    input  logic                disp_valid,
    output logic                disp_ready,
    input  mem_pkg::mem_op_t    disp_op,
    input  mem_pkg::xlen_t      disp_rs1,
    input  mem_pkg::xlen_t      disp_rs2,
    input  mem_pkg::imm_t       disp_imm,
    input  mem_pkg::preg_idx_t  disp_rd_preg_idx,
    input  mem_pkg::rob_idx_t   disp_rob_idx,

    output logic                iq_valid,
    input  logic                iq_ready,
    output mem_pkg::mem_op_t    iq_op,
    output mem_pkg::xlen_t      iq_rs1,
    output mem_pkg::xlen_t      iq_rs2,
    output mem_pkg::imm_t       iq_imm,
    output mem_pkg::preg_idx_t  iq_rd_preg_idx,
    output mem_pkg::rob_idx_t   iq_rob_idx
);
    import mem_pkg::*;

    typedef logic [$clog2(IQ_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(IQ_DEPTH+1)-1:0] cnt_t;

    mem_op_t    op_mem   [IQ_DEPTH];
    xlen_t      rs1_mem  [IQ_DEPTH];
    xlen_t      rs2_mem  [IQ_DEPTH];
    imm_t       imm_mem  [IQ_DEPTH];
    preg_idx_t  preg_mem [IQ_DEPTH];
    rob_idx_t   rob_mem  [IQ_DEPTH];

    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;
    logic       full;
    logic       push;
    logic       pop;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(IQ_DEPTH - 1)) ? '0 : ptr_t'(ptr + 1'b1);
    endfunction

    assign full       = (count == cnt_t'(IQ_DEPTH));
    assign disp_ready = !full;
    assign iq_valid   = (count != '0);
    assign push       = disp_valid && disp_ready;
    assign pop        = iq_valid && iq_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= cnt_t'(count + 1'b1);
                2'b01:   count <= cnt_t'(count - 1'b1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]   <= disp_op;
            rs1_mem[wr_ptr]  <= disp_rs1;
            rs2_mem[wr_ptr]  <= disp_rs2;
            imm_mem[wr_ptr]  <= disp_imm;
            preg_mem[wr_ptr] <= disp_rd_preg_idx;
            rob_mem[wr_ptr]  <= disp_rob_idx;
        end
    end

    // Oldest entry
    assign iq_op          = op_mem[rd_ptr];
    assign iq_rs1         = rs1_mem[rd_ptr];
    assign iq_rs2         = rs2_mem[rd_ptr];
    assign iq_imm         = imm_mem[rd_ptr];
    assign iq_rd_preg_idx = preg_mem[rd_ptr];
    assign iq_rob_idx     = rob_mem[rd_ptr];

    // Occupancy within depth, pointers met when full
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        (count <= cnt_t'(IQ_DEPTH)) && (!full || (wr_ptr == rd_ptr)));

endmodule

/* rtl/mem_addr_gen.sv */
`timescale 1ns/1ps

module mem_addr_gen (
    input  logic                clk,
    input  logic                reset,

    input  logic                iq_valid,
    output logic                iq_ready,
    input  mem_pkg::mem_op_t    iq_op,
    input  mem_pkg::xlen_t      iq_rs1,
    input  mem_pkg::xlen_t      iq_rs2,
    input  mem_pkg::imm_t       iq_imm,
    input  mem_pkg::preg_idx_t  iq_rd_preg_idx,
    input  mem_pkg::rob_idx_t   iq_rob_idx,

    output logic                ag_valid,
    input  logic                ag_ready,
    output mem_pkg::xlen_t      ag_addr,
    output mem_pkg::xlen_t      ag_wdata,
    output mem_pkg::strb_t      ag_strb,
    output logic                ag_write,
    output mem_pkg::mem_op_t    ag_op,
    output logic                ag_misaligned,
    output mem_pkg::preg_idx_t  ag_rd_preg_idx,
    output mem_pkg::rob_idx_t   ag_rob_idx
);
    import mem_pkg::*;

    xlen_t  eff_addr;
    xlen_t  lane_data;
    strb_t  strb;
    logic   is_store;
    logic   misaligned;
    logic   load_en;

    //--------------------
    // Address and lanes
    //--------------------
    assign eff_addr  = iq_rs1 + {{20{iq_imm[11]}}, iq_imm};
    assign lane_data = iq_rs2 << {eff_addr[1:0], 3'b000};

    always_comb begin
        strb       = 4'b0000;
        misaligned = 1'b0;
        case (iq_op)
            op_lb, op_lbu, op_sb: begin
                strb = 4'b0001 << eff_addr[1:0];
            end
            op_lh, op_lhu, op_sh: begin
                strb       = 4'b0011 << eff_addr[1:0];
                misaligned = eff_addr[0];
            end
            op_lw, op_sw: begin
                strb       = 4'b1111;
                misaligned = (eff_addr[1:0] != 2'b00);
            end
            default: begin
                strb       = 4'b0000;
                misaligned = 1'b0;
            end
        endcase
    end

    assign is_store = iq_op inside {op_sb, op_sh, op_sw};

    //--------------------
    // Pipeline register
    //--------------------
    // Refills in the same cycle the LSU takes the current item
    assign iq_ready = !ag_valid || ag_ready;
    assign load_en  = iq_valid && iq_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ag_valid <= 1'b0;
        end else if (iq_ready) begin
            ag_valid <= iq_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            ag_addr        <= eff_addr;
            ag_wdata       <= lane_data;
            ag_strb        <= strb;
            ag_write       <= is_store;
            ag_op          <= iq_op;
            ag_misaligned  <= misaligned;
            ag_rd_preg_idx <= iq_rd_preg_idx;
            ag_rob_idx     <= iq_rob_idx;
        end
    end

    // Stalled item must not change under the LSU
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        ag_valid && !ag_ready |=> ag_valid && $stable(ag_addr) && $stable(ag_wdata)
            && $stable(ag_strb) && $stable(ag_write) && $stable(ag_op)
            && $stable(ag_misaligned) && $stable(ag_rd_preg_idx) && $stable(ag_rob_idx));

endmodule

/* rtl/mem_lsu.sv */
`timescale 1ns/1ps

module mem_lsu (
    input  logic                clk,
    input  logic                reset,

    input  logic                ag_valid,
    output logic                ag_ready,
    input  mem_pkg::xlen_t      ag_addr,
    input  mem_pkg::xlen_t      ag_wdata,
    input  mem_pkg::strb_t      ag_strb,
    input  logic                ag_write,
    input  mem_pkg::mem_op_t    ag_op,
    input  logic                ag_misaligned,
    input  mem_pkg::preg_idx_t  ag_rd_preg_idx,
    input  mem_pkg::rob_idx_t   ag_rob_idx,

    output logic                nc_cmd_valid,
    input  logic                nc_cmd_ready,
    output mem_pkg::xlen_t      nc_cmd_addr,
    output logic                nc_cmd_read,
    output mem_pkg::xlen_t      nc_cmd_wdata,
    output mem_pkg::strb_t      nc_cmd_wmask,
    output logic                nc_resp_ready,
    input  logic                nc_resp_valid,
    input  mem_pkg::xlen_t      nc_resp_rdata,
    input  logic                nc_resp_err,

    output logic                prf_we,
    output mem_pkg::preg_idx_t  prf_we_idx,
    output mem_pkg::xlen_t      prf_wdata,
    output logic                rob_cmplt_en,
    output mem_pkg::rob_idx_t   rob_cmplt_idx,
    output logic                rob_cmplt_err
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_cmd,
        st_resp,
        st_cmplt
    } lsu_state_t;

    lsu_state_t state;
    lsu_state_t state_nxt;

    xlen_t      addr_q;
    xlen_t      wdata_q;
    strb_t      strb_q;
    logic       write_q;
    mem_op_t    op_q;
    logic       misaligned_q;
    preg_idx_t  preg_q;
    rob_idx_t   rob_q;

    logic       accept;
    logic       cmd_fire;
    logic       resp_fire;
    logic       cmplt_fire;
    xlen_t      rdata_shift;
    xlen_t      ld_data;

    assign ag_ready      = (state == st_idle);
    assign accept        = ag_valid && ag_ready;
    assign nc_cmd_valid  = (state == st_cmd);
    assign cmd_fire      = nc_cmd_valid && nc_cmd_ready;
    assign nc_resp_ready = (state == st_resp);
    assign resp_fire     = nc_resp_valid && nc_resp_ready;

    // Misaligned ops report from the complete state, bus ops on the response
    assign cmplt_fire = resp_fire || ((state == st_cmplt) && misaligned_q);

    //--------------------
    // FSM
    //--------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_nxt = ag_misaligned ? st_cmplt : st_cmd;
                end
            end
            st_cmd: begin
                if (cmd_fire) begin
                    state_nxt = st_resp;
                end
            end
            st_resp: begin
                if (resp_fire) begin
                    state_nxt = st_cmplt;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= ag_addr;
            wdata_q      <= ag_wdata;
            strb_q       <= ag_strb;
            write_q      <= ag_write;
            op_q         <= ag_op;
            misaligned_q <= ag_misaligned;
            preg_q       <= ag_rd_preg_idx;
            rob_q        <= ag_rob_idx;
        end
    end

    // Bus command, word aligned
    assign nc_cmd_addr  = {addr_q[31:2], 2'b00};
    assign nc_cmd_read  = !write_q;
    assign nc_cmd_wdata = wdata_q;
    assign nc_cmd_wmask = strb_q;

    //--------------------
    // Load data
    //--------------------
    assign rdata_shift = nc_resp_rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            op_lb:   ld_data = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
            op_lbu:  ld_data = {24'b0, rdata_shift[7:0]};
            op_lh:   ld_data = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
            op_lhu:  ld_data = {16'b0, rdata_shift[15:0]};
            default: ld_data = nc_resp_rdata;
        endcase
    end

    // Writeback and completion pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            prf_we       <= 1'b0;
            rob_cmplt_en <= 1'b0;
        end else begin
            prf_we       <= resp_fire && !write_q && !nc_resp_err;
            rob_cmplt_en <= cmplt_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (cmplt_fire) begin
            prf_we_idx    <= preg_q;
            prf_wdata     <= ld_data;
            rob_cmplt_idx <= rob_q;
            rob_cmplt_err <= misaligned_q || nc_resp_err;
        end
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        nc_cmd_valid && !nc_cmd_ready |=> nc_cmd_valid && $stable(nc_cmd_addr)
            && $stable(nc_cmd_read) && $stable(nc_cmd_wdata) && $stable(nc_cmd_wmask));

endmodule

/* rtl/mem_block.sv */
`timescale 1ns/1ps

module mem_block (
    input  logic                clk,
    input  logic                reset,

    //--------------------
    // Dispatch
    //--------------------
    input  logic                disp_valid,
    output logic                disp_ready,
    input  mem_pkg::mem_op_t    disp_op,
    input  mem_pkg::xlen_t      disp_rs1,
    input  mem_pkg::xlen_t      disp_rs2,
    input  mem_pkg::imm_t       disp_imm,
    input  mem_pkg::preg_idx_t  disp_rd_preg_idx,
    input  mem_pkg::rob_idx_t   disp_rob_idx,

    //--------------------
    // Uncached bus
    //--------------------
    output logic                nc_cmd_valid,
    input  logic                nc_cmd_ready,
    output mem_pkg::xlen_t      nc_cmd_addr,
    output logic                nc_cmd_read,
    output mem_pkg::xlen_t      nc_cmd_wdata,
    output mem_pkg::strb_t      nc_cmd_wmask,
    output logic                nc_resp_ready,
    input  logic                nc_resp_valid,
    input  mem_pkg::xlen_t      nc_resp_rdata,
    input  logic                nc_resp_err,

    // Register file and ROB
    output logic                prf_we,
    output mem_pkg::preg_idx_t  prf_we_idx,
    output mem_pkg::xlen_t      prf_wdata,
    output logic                rob_cmplt_en,
    output mem_pkg::rob_idx_t   rob_cmplt_idx,
    output logic                rob_cmplt_err
);
    import mem_pkg::*;

    // Queue head
    logic       iq_valid;
    logic       iq_ready;
    mem_op_t    iq_op;
    xlen_t      iq_rs1;
    xlen_t      iq_rs2;
    imm_t       iq_imm;
    preg_idx_t  iq_rd_preg_idx;
    rob_idx_t   iq_rob_idx;

    // Address generation result
    logic       ag_valid;
    logic       ag_ready;
    xlen_t      ag_addr;
    xlen_t      ag_wdata;
    strb_t      ag_strb;
    logic       ag_write;
    mem_op_t    ag_op;
    logic       ag_misaligned;
    preg_idx_t  ag_rd_preg_idx;
    rob_idx_t   ag_rob_idx;

    mem_issue_queue u_issue_queue (.*);

    mem_addr_gen u_addr_gen (.*);

    mem_lsu u_lsu (.*);

endmodule

/* test/tb_mem_block.sv */
`timescale 1ns/1ps

module tb_mem_block;
    import mem_pkg::*;

    typedef struct packed {
        mem_op_t    op;
        xlen_t      rs1;
        xlen_t      rs2;
        imm_t       imm;
        preg_idx_t  rd;
        rob_idx_t   rob;
        logic       err;
        xlen_t      data;
    } row_t;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       disp_valid = 1'b0;
    mem_op_t    disp_op = op_lw;
    xlen_t      disp_rs1 = '0;
    xlen_t      disp_rs2 = '0;
    imm_t       disp_imm = '0;
    preg_idx_t  disp_rd_preg_idx = '0;
    rob_idx_t   disp_rob_idx = '0;
    logic       nc_cmd_ready = 1'b0;
    logic       nc_resp_valid = 1'b0;
    xlen_t      nc_resp_rdata = '0;
    logic       nc_resp_err = 1'b0;

    logic       disp_ready, nc_cmd_valid, nc_cmd_read, nc_resp_ready;
    xlen_t      nc_cmd_addr, nc_cmd_wdata, prf_wdata;
    strb_t      nc_cmd_wmask;
    logic       prf_we, rob_cmplt_en, rob_cmplt_err;
    preg_idx_t  prf_we_idx;
    rob_idx_t   rob_cmplt_idx;

    row_t           rows [$];
    xlen_t          mem [16];
    logic [15:0]    lfsr = 16'd74;
    int             cmd_count = 0;
    int             resp_delay = 0;
    logic           resp_pending = 1'b0;
    xlen_t          resp_data;
    logic           resp_error;
    logic           cmd_fire;
    logic           resp_fire;

    mem_block u_dut (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic int random_bits(input int n);
        int value = 0;
        repeat (n) begin
            lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    function automatic logic is_misaligned(input row_t r);
        xlen_t addr;
        logic  misaligned;
        addr       = r.rs1 + xlen_t'(int'($signed(r.imm)));
        misaligned = 1'b0;
        if (r.op inside {op_lh, op_lhu, op_sh}) begin
            misaligned = addr[0];
        end else if (r.op inside {op_lw, op_sw}) begin
            misaligned = (addr[1:0] != 2'b00);
        end
        return misaligned;
    endfunction

    //--------------------
    // Failure handling
    //--------------------
    task automatic report_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("gave up waiting for %s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_rob(input rob_idx_t got, input logic got_err,
                             input rob_idx_t exp, input logic exp_err);
        if (got !== exp || got_err !== exp_err) begin
            report_mismatch($sformatf("completion rob %0d err %b, expected rob %0d err %b",
                got, got_err, exp, exp_err));
        end
    endtask

    task automatic check_preg(input logic got_we, input preg_idx_t got,
                              input logic exp_we, input preg_idx_t exp);
        if (got_we !== exp_we || (exp_we && got !== exp)) begin
            report_mismatch($sformatf("prf write %b to p%0d, expected %b to p%0d",
                got_we, got, exp_we, exp));
        end
    endtask

    //--------------------
    // Bus responder
    //--------------------
    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'h80A0C0E0 + 32'h01010101 * xlen_t'(i);
        end
        forever begin
            @(negedge clk);
            cmd_fire  = nc_cmd_valid && nc_cmd_ready;
            resp_fire = nc_resp_valid && nc_resp_ready;
            if (cmd_fire) begin
                cmd_count++;
                if (nc_cmd_addr[1:0] != 2'b00) begin
                    report_mismatch($sformatf("bus address %h is not word aligned",
                        nc_cmd_addr));
                end
                resp_error = (nc_cmd_addr >= 32'h1000);
                if (!nc_cmd_read && !resp_error) begin
                    for (int b = 0; b < 4; b++) begin
                        if (nc_cmd_wmask[b]) begin
                            mem[nc_cmd_addr[5:2]][8*b +: 8] = nc_cmd_wdata[8*b +: 8];
                        end
                    end
                end
                resp_data    = mem[nc_cmd_addr[5:2]];
                resp_delay   = random_bits(2);
                resp_pending = 1'b1;
            end
            @(posedge clk);
            #1;
            if (resp_fire) begin
                nc_resp_valid = 1'b0;
            end
            if (resp_pending && resp_delay == 0) begin
                nc_resp_valid = 1'b1;
                nc_resp_rdata = resp_data;
                nc_resp_err   = resp_error;
                resp_pending  = 1'b0;
            end else if (resp_pending) begin
                resp_delay--;
            end
            nc_cmd_ready = (random_bits(1) != 0);
        end
    end

    task automatic drive_rows();
        int waited;
        foreach (rows[i]) begin
            disp_valid       = 1'b1;
            disp_op          = rows[i].op;
            disp_rs1         = rows[i].rs1;
            disp_rs2         = rows[i].rs2;
            disp_imm         = rows[i].imm;
            disp_rd_preg_idx = rows[i].rd;
            disp_rob_idx     = rows[i].rob;
            waited = 0;
            @(negedge clk);
            while (!disp_ready) begin
                waited++;
                if (waited > 100) begin
                    abort_on_timeout("disp_ready to rise");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        disp_valid = 1'b0;
    endtask

    // Completions arrive in dispatch order, one per row
    task automatic check_rows();
        int     waited;
        int     exp_cmds = 0;
        logic   exp_we;
        foreach (rows[i]) begin
            waited = 0;
            @(negedge clk);
            while (!rob_cmplt_en) begin
                waited++;
                if (waited > 200) begin
                    abort_on_timeout($sformatf("completion of row %0d", i));
                end
                @(negedge clk);
            end
            exp_we = !rows[i].err && !(rows[i].op inside {op_sb, op_sh, op_sw});
            check_rob(rob_cmplt_idx, rob_cmplt_err, rows[i].rob, rows[i].err);
            check_preg(prf_we, prf_we_idx, exp_we, rows[i].rd);
            if (exp_we) begin
                check_data(prf_wdata, rows[i].data, "load result");
            end
            if (!is_misaligned(rows[i])) begin
                exp_cmds++;
            end
            if (cmd_count != exp_cmds) begin
                report_mismatch($sformatf("%0d bus commands, expected %0d", cmd_count, exp_cmds));
            end
        end
    endtask

    initial begin
        rows = '{
            // op     rs1           rs2           imm      rd     rob    err   data
            '{op_sw,  32'h00000000, 32'h12345678, 12'h000, 6'd1,  5'd0,  1'b0, 32'h00000000},
            '{op_lw,  32'h00000000, 32'h00000000, 12'h000, 6'd2,  5'd1,  1'b0, 32'h12345678},
            '{op_lb,  32'h00000004, 32'h00000000, 12'h000, 6'd3,  5'd2,  1'b0, 32'hFFFFFFE1},
            '{op_lb,  32'h00000020, 32'h00000000, 12'hFE5, 6'd4,  5'd3,  1'b0, 32'hFFFFFFC1},
            '{op_lb,  32'h00000004, 32'h00000000, 12'h002, 6'd5,  5'd4,  1'b0, 32'hFFFFFFA1},
            '{op_lb,  32'h00000004, 32'h00000000, 12'h003, 6'd6,  5'd5,  1'b0, 32'hFFFFFF81},
            '{op_lh,  32'h00000004, 32'h00000000, 12'h000, 6'd7,  5'd6,  1'b0, 32'hFFFFC1E1},
            '{op_lh,  32'h00000004, 32'h00000000, 12'h002, 6'd8,  5'd7,  1'b0, 32'hFFFF81A1},
            '{op_lbu, 32'h00000004, 32'h00000000, 12'h001, 6'd9,  5'd8,  1'b0, 32'h000000C1},
            '{op_lhu, 32'h00000004, 32'h00000000, 12'h002, 6'd10, 5'd9,  1'b0, 32'h000081A1},
            '{op_sb,  32'h00000008, 32'hAABBCC55, 12'h001, 6'd11, 5'd10, 1'b0, 32'h00000000},
            '{op_sh,  32'h00000008, 32'h1234BEEF, 12'h002, 6'd12, 5'd11, 1'b0, 32'h00000000},
            '{op_lw,  32'h00000008, 32'h00000000, 12'h000, 6'd13, 5'd12, 1'b0, 32'hBEEF55E2},
            '{op_lh,  32'h0000000C, 32'h00000000, 12'h001, 6'd14, 5'd13, 1'b1, 32'h00000000},
            '{op_sw,  32'h00000010, 32'hDEADBEEF, 12'h002, 6'd15, 5'd14, 1'b1, 32'h00000000},
            '{op_lw,  32'h00000010, 32'h00000000, 12'h000, 6'd16, 5'd15, 1'b0, 32'h84A4C4E4},
            '{op_lw,  32'h00001000, 32'h00000000, 12'h000, 6'd17, 5'd16, 1'b1, 32'h00000000},
            '{op_lbu, 32'h00000020, 32'h00000000, 12'h7F9, 6'd18, 5'd17, 1'b0, 32'h000000C6}
        };
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            drive_rows();
            check_rows();
        join
        $display("all tests passed");
        $finish;
    end

endmodule

/* mem_block.f */
rtl/mem_pkg.sv
rtl/mem_issue_queue.sv
rtl/mem_addr_gen.sv
rtl/mem_lsu.sv
rtl/mem_block.sv
test/tb_mem_block.sv

/* Makefile */
TOP := tb_mem_block

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f mem_block.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
